//--- design/display_pkg.sv
//////////////////////////////////////////////////////////////////////
// 640x480 raster timing constants and the screen position struct
// imported by the timing stage and every stage that reads position
//////////////////////////////////////////////////////////////////////

package display_pkg;

    localparam int unsigned cordw = 10;  // covers 0..1023, enough for 800 and 525

    // horizontal, in pixels
    localparam logic [cordw-1:0] h_res      = cordw'(640);  // last active + 1
    localparam logic [cordw-1:0] h_fp_end   = cordw'(656);  // hsync goes low here
    localparam logic [cordw-1:0] h_sync_end = cordw'(752);  // 96 pixel sync pulse
    localparam logic [cordw-1:0] h_total    = cordw'(800);

    // vertical, in lines
    localparam logic [cordw-1:0] v_res        = cordw'(480);
    localparam logic [cordw-1:0] v_sync_start = cordw'(490);
    localparam logic [cordw-1:0] v_sync_end   = cordw'(492);  // two line pulse
    localparam logic [cordw-1:0] v_total      = cordw'(525);

    // one raster position with everything decoded from it
    typedef struct packed {
        logic [cordw-1:0] sx;
        logic [cordw-1:0] sy;
        logic             de;     // active area
        logic             hsync;  // active low
        logic             vsync;  // active low
        logic             line;   // pulse at sx == h_res
        logic             frame;  // pulse at (0,0)
    } screen_pos_t;

    // value held while in reset, syncs inactive
    localparam screen_pos_t pos_idle = '{sx: '0, sy: '0, de: 1'b0, hsync: 1'b1,
                                         vsync: 1'b1, line: 1'b0, frame: 1'b0};

endpackage

//--- design/sprite_pkg.sv
//////////////////////////////////////////////////////////////////////
// font, sprite placement and starfield constants plus the colour type
//////////////////////////////////////////////////////////////////////

package sprite_pkg;

    // glyph rom
    localparam int unsigned font_width      = 8;  // pixels per row, also rom word width
    localparam int unsigned font_height     = 8;  // rows per glyph
    localparam int unsigned font_glyphs     = 5;  // stored in order A C E F S
    localparam int unsigned font_rom_depth  = font_glyphs * font_height;
    localparam int unsigned font_addr_width = $clog2(font_rom_depth);
    localparam              font_file       = "design/font_glyphs.mem";

    // sprite placement, fixed at build time
    localparam int unsigned spr_x     = 192;  // left edge
    localparam int unsigned spr_y     = 112;  // top edge
    localparam int unsigned spr_scale = 32;   // same factor on both axes
    localparam int unsigned spr_size  = font_width * spr_scale;  // 256 square
    localparam int unsigned spr_glyph = 3;    // 'F'

    // 4 bits per channel
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    localparam rgb_t spr_colour = '{r: 4'hF, g: 4'hC, b: 4'h0};  // orange

    // galois lfsr, x^21 + x^19 + 1
    localparam int unsigned lfsr_width = 21;
    localparam logic [lfsr_width-1:0] lfsr_taps = 21'h140000;

    // per layer settings, index 0 has the highest priority
    localparam int unsigned sf_layers = 3;
    localparam logic [lfsr_width-1:0] sf_seed [sf_layers] = '{21'h9A9A9, 21'hA9A9A, 21'h1FFFFF};
    localparam logic [lfsr_width-1:0] sf_mask [sf_layers] = '{21'hFFF, 21'hFFF, 21'h7FF};
    localparam int sf_inc [sf_layers] = '{-1, -2, -4};  // drift per frame, in pixels

endpackage

//--- design/display_timings.sv
//////////////////////////////////////////////////////////////////////
// stage 1, raster position counter with registered sync and strobes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module display_timings
    import display_pkg::*;
(
    input  logic        clk_pix,
    input  logic        rst_n,
    output screen_pos_t pos
);

    logic             run;    // low until the first edge after reset
    logic [cordw-1:0] x_nxt;
    logic [cordw-1:0] y_nxt;

    // next position, (0,0) on the first cycle out of reset
    always_comb begin
        x_nxt = '0;
        y_nxt = '0;
        if (run) begin
            if (pos.sx == h_total - 1'b1) begin  // end of line
                x_nxt = '0;
                if (pos.sy == v_total - 1'b1) begin
                    y_nxt = '0;  // end of frame
                end else begin
                    y_nxt = pos.sy + 1'b1;
                end
            end else begin
                x_nxt = pos.sx + 1'b1;
                y_nxt = pos.sy;
            end
        end
    end

    // decode from the next position so every field lines up with sx, sy
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            run <= 1'b0;
            pos <= pos_idle;
        end else begin
            run       <= 1'b1;
            pos.sx    <= x_nxt;
            pos.sy    <= y_nxt;
            pos.de    <= (x_nxt < h_res) && (y_nxt < v_res);
            pos.hsync <= !((x_nxt >= h_fp_end) && (x_nxt < h_sync_end));
            pos.vsync <= !((y_nxt >= v_sync_start) && (y_nxt < v_sync_end));
            pos.line  <= (x_nxt == h_res);  // start of horizontal blanking
            pos.frame <= (x_nxt == '0) && (y_nxt == '0);
        end
    end

endmodule

//--- design/font_rom.sv
//////////////////////////////////////////////////////////////////////
// glyph row rom, one 8 pixel row per read, one cycle latency
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module font_rom
    import sprite_pkg::*;
(
    input  logic                       clk_pix,
    input  logic [font_addr_width-1:0] addr,  // glyph * font_height + row
    output logic [font_width-1:0]      data   // msb is the leftmost pixel
);

    logic [font_width-1:0] mem [font_rom_depth];

    initial begin
        $readmemh(font_file, mem);  // one hex row per line
    end

    // registered read, maps onto block ram
    always_ff @(posedge clk_pix) begin
        data <= mem[addr];
    end

endmodule

//--- design/sprite.sv
//////////////////////////////////////////////////////////////////////
// stage 2a, scaled glyph sprite, fetches one rom row per line in
// horizontal blanking and outputs a registered pixel bit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sprite
    import display_pkg::*;
    import sprite_pkg::*;
(
    input  logic                       clk_pix,
    input  logic                       rst_n,
    input  screen_pos_t                pos,
    output logic [font_addr_width-1:0] rom_addr,
    input  logic [font_width-1:0]      rom_data,
    output logic                       pix        // one cycle after pos
);

    localparam int unsigned rep_bits = $clog2(spr_scale);
    localparam int unsigned row_bits = $clog2(font_height);

    localparam logic [cordw-1:0]           x0     = cordw'(spr_x);
    localparam logic [cordw-1:0]           x_end  = cordw'(spr_x + spr_size);
    localparam logic [cordw-1:0]           y0     = cordw'(spr_y);
    localparam logic [font_addr_width-1:0] g_base = font_addr_width'(spr_glyph * font_height);

    typedef enum logic {
        st_idle,  // above or below the sprite
        st_draw   // current line crosses the sprite
    } spr_state_t;

    spr_state_t            state;
    spr_state_t            state_nxt;
    logic [row_bits-1:0]   row;        // glyph row being drawn
    logic [row_bits-1:0]   row_nxt;
    logic [rep_bits-1:0]   rep;        // line within the scaled row
    logic [rep_bits-1:0]   rep_nxt;
    logic                  line_d;     // rom data valid
    logic [font_width-1:0] row_buf;    // latched glyph row
    logic [font_width-1:0] shift;      // msb is the pixel on screen
    logic [rep_bits-1:0]   px_cnt;     // pixel within the scaled column
    logic                  in_x;
    logic                  load;

    // vertical tracking, only moves on the line strobe
    always_comb begin
        state_nxt = state;
        row_nxt   = row;
        rep_nxt   = rep;
        if (pos.line) begin
            case (state)
                st_idle: begin
                    if (pos.sy == y0 - 1'b1) begin  // next line is the top edge
                        state_nxt = st_draw;
                        row_nxt   = '0;
                        rep_nxt   = '0;
                    end
                end
                st_draw: begin
                    if (rep == '1) begin  // row shown spr_scale times
                        rep_nxt = '0;
                        if (row == '1) begin
                            state_nxt = st_idle;  // bottom edge passed
                        end else begin
                            row_nxt = row + 1'b1;
                        end
                    end else begin
                        rep_nxt = rep + 1'b1;
                    end
                end
                default: state_nxt = st_idle;
            endcase
        end
    end

    // fetch slot is the line strobe, row for the coming line
    assign rom_addr = pos.line ? g_base + font_addr_width'(row_nxt) : '0;

    assign in_x = (pos.sx >= x0) && (pos.sx < x_end);
    assign load = (pos.sx == x0 - 1'b1);  // one pixel ahead of the left edge

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            state  <= st_idle;
            row    <= '0;
            rep    <= '0;
            line_d <= 1'b0;
            px_cnt <= '0;
            pix    <= 1'b0;
        end else begin
            state  <= state_nxt;
            row    <= row_nxt;
            rep    <= rep_nxt;
            line_d <= pos.line;
            if (load) begin
                px_cnt <= '0;
            end else if (in_x) begin
                px_cnt <= px_cnt + 1'b1;  // wraps every spr_scale pixels
            end
            pix <= (state == st_draw) && in_x && shift[font_width-1];
        end
    end

    // row data, no reset needed
    always_ff @(posedge clk_pix) begin
        if (line_d) begin
            row_buf <= rom_data;
        end
        if (load) begin
            shift <= row_buf;
        end else if (in_x && px_cnt == '1) begin
            shift <= shift << 1;  // next glyph column
        end
    end

endmodule

//--- design/starfield.sv
//////////////////////////////////////////////////////////////////////
// stage 2b, one starfield layer from a galois lfsr that restarts a
// little short of a full frame so the stars drift left
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module starfield
    import display_pkg::*;
    import sprite_pkg::*;
#(
    parameter int unsigned layer = 0  // index into the package arrays
) (
    input  logic        clk_pix,
    input  logic        rst_n,
    input  screen_pos_t pos,
    output logic        star_on,  // one cycle after pos
    output logic [7:0]  star
);

    localparam int frame_cycles = int'(h_total) * int'(v_total);  // 420000
    localparam int cntw         = $clog2(frame_cycles);
    localparam logic [cntw-1:0]       cnt_load = cntw'(frame_cycles + sf_inc[layer] - 1);
    localparam logic [lfsr_width-1:0] seed     = sf_seed[layer];
    localparam logic [lfsr_width-1:0] mask     = sf_mask[layer];

    logic [lfsr_width-1:0] lfsr;
    logic [cntw-1:0]       cnt;     // cycles to the next restart
    logic                  synced;  // first frame strobe seen
    logic                  run;

    assign run = synced | pos.frame;  // held at the seed until (0,0)

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            synced  <= 1'b0;
            cnt     <= cnt_load;
            lfsr    <= seed;
            star_on <= 1'b0;
        end else begin
            synced <= run;
            if (run) begin
                if (cnt == '0) begin  // wrap, frame minus drift
                    cnt  <= cnt_load;
                    lfsr <= seed;
                end else begin
                    cnt  <= cnt - 1'b1;
                    lfsr <= lfsr[0] ? (lfsr >> 1) ^ lfsr_taps : lfsr >> 1;
                end
            end
            star_on <= (lfsr & mask) == mask;  // all masked bits set
        end
    end

    // brightness from bits outside every mask
    always_ff @(posedge clk_pix) begin
        star <= lfsr[lfsr_width-1 -: 8];
    end

endmodule

//--- design/space_f_top.sv
//////////////////////////////////////////////////////////////////////
// space 'F' top level, timing, glyph sprite over three starfields,
// registered 12-bit vga colour and syncs two cycles after position
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module space_f_top
    import display_pkg::*;
    import sprite_pkg::*;
(
    input  logic clk_pix,
    input  logic rst_n,
    output logic vga_hsync,
    output logic vga_vsync,
    output rgb_t vga_rgb
);

    screen_pos_t                        pos;        // stage 1 out
    screen_pos_t                        pos_d;      // aligned with stage 2
    logic [font_addr_width-1:0]         font_addr;
    logic [font_width-1:0]              font_data;
    logic                               spr_pix;
    logic [sf_layers-1:0]               sf_on;
    logic [sf_layers-1:0][7:0]          sf_star;
    logic [3:0]                         starlight;
    rgb_t                               colour;

    display_timings u_timings (
        .clk_pix,
        .rst_n,
        .pos
    );

    font_rom u_font_rom (
        .clk_pix,
        .addr (font_addr),
        .data (font_data)
    );

    sprite u_sprite (
        .clk_pix,
        .rst_n,
        .pos,
        .rom_addr (font_addr),
        .rom_data (font_data),
        .pix      (spr_pix)
    );

    for (genvar i = 0; i < sf_layers; i++) begin : g_sf
        starfield #(.layer(i)) u_starfield (
            .clk_pix,
            .rst_n,
            .pos,
            .star_on (sf_on[i]),
            .star    (sf_star[i])
        );
    end

    // colour mux, sprite over stars, layer 0 over 1 over 2
    always_comb begin
        starlight = 4'h0;
        if (sf_on[0]) begin
            starlight = sf_star[0][7:4];
        end else if (sf_on[1]) begin
            starlight = sf_star[1][7:4];
        end else if (sf_on[2]) begin
            starlight = sf_star[2][7:4];
        end
        colour = '0;  // black in blanking
        if (pos_d.de) begin
            colour = spr_pix ? spr_colour : '{r: starlight, g: starlight, b: starlight};
        end
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            pos_d     <= pos_idle;
            vga_rgb   <= '0;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
        end else begin
            pos_d     <= pos;          // match the stage 2 register
            vga_rgb   <= colour;
            vga_hsync <= pos_d.hsync;
            vga_vsync <= pos_d.vsync;
        end
    end

endmodule

//--- sim/space_f_props.sv
//////////////////////////////////////////////////////////////////////
// concurrent checks on the top level ports, bound into space_f_top
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module space_f_props
    import display_pkg::*;
    import sprite_pkg::*;
(
    input logic        clk_pix,
    input logic        rst_n,
    input logic        vga_hsync,
    input logic        vga_vsync,
    input rgb_t        vga_rgb,
    input screen_pos_t pos_d
);

    int   low_cnt = 0;     // hsync low run length
    logic seen    = 1'b0;  // first edge passed
    int   errors  = 0;     // assertion failures so far

    always @(posedge clk_pix) begin
        low_cnt <= vga_hsync ? 0 : low_cnt + 1;
        seen    <= 1'b1;
    end

    hsync_width: assert property (@(posedge clk_pix) disable iff (!rst_n)
        $rose(vga_hsync) |-> low_cnt == 96)
        else begin
            $error("hsync pulse was %0d cycles, not 96", low_cnt);
            errors++;
        end

    // rgb lags pos_d by one register
    black_blank: assert property (@(posedge clk_pix) disable iff (!rst_n)
        !$past(pos_d.de) |-> vga_rgb == '0)
        else begin
            $error("colour %h outside the active area", vga_rgb);
            errors++;
        end

    reset_idle: assert property (@(posedge clk_pix)
        seen && $past(!rst_n) |-> vga_rgb == '0 && vga_hsync && vga_vsync)
        else begin
            $error("outputs not idle during reset");
            errors++;
        end

endmodule

bind space_f_top space_f_props u_props (
    .clk_pix,
    .rst_n,
    .vga_hsync,
    .vga_vsync,
    .vga_rgb,
    .pos_d
);

//--- sim/space_f_checker.sv
//////////////////////////////////////////////////////////////////////
// follows the raster from reset release, models stars by the lfsr
// rule and compares the ports at each probe of the data file
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module space_f_checker
    import display_pkg::*;
    import sprite_pkg::*;
(
    input  logic clk_pix,
    input  logic rst_n,
    input  logic vga_hsync,
    input  logic vga_vsync,
    input  rgb_t vga_rgb,
    output logic done,
    output int   passes,
    output int   fails,
    output int   frames   // frames spanned by the probe list
);

    localparam int frame_cycles = int'(h_total) * int'(v_total);
    localparam int fields       = 7;   // name kind frame x y rgb sync
    localparam int probe_max    = 64;

    logic [15:0]           td [fields*probe_max];
    logic [lfsr_width-1:0] st [sf_layers];  // model lfsr per layer
    int                    ph [sf_layers];  // position in the layer period
    int   edges    = 0;                     // clock edges since release
    logic rst_seen = 1'b0;
    logic rst_bad  = 1'b0;
    rgb_t rst_rgb;                          // first bad value in reset
    logic [1:0] rst_sync;
    logic scan_on  = 1'b0;
    int   p, scan_fr, scan_y1, scan_bad, scan_stars;
    rgb_t scan_exp, scan_act;

    function automatic string test_name(input logic [15:0] id);
        case (id)
            16'd1:   return "blank";
            16'd2:   return "sync";
            16'd3:   return "sprite";
            16'd4:   return "edge";
            16'd5:   return "stars";
            default: return "probe";
        endcase
    endfunction

    // galois step for x^21 + x^19 + 1
    function automatic logic [lfsr_width-1:0] lfsr_next(input logic [lfsr_width-1:0] v);
        return v[0] ? (v >> 1) ^ 21'h140000 : v >> 1;
    endfunction

    // grey star of the first lit layer and black outside the active area
    function automatic rgb_t star_colour(input int px, input int py);
        logic [3:0] s;
        s = 4'h0;
        for (int i = sf_layers - 1; i >= 0; i--) begin
            if ((st[i] & sf_mask[i]) == sf_mask[i]) s = st[i][20:17];
        end
        if (px < 640 && py < 480) return '{r: s, g: s, b: s};
        return '0;
    endfunction

    initial begin
        done   = 1'b0;
        passes = 0;
        fails  = 0;
        frames = 0;
        p      = 0;
        $readmemh("sim/space_f_testdata.mem", td);
        for (int i = 0; i < probe_max && td[i*fields] != 16'h00ff; i++) begin
            if (int'(td[i*fields+2]) + 1 > frames) frames = int'(td[i*fields+2]) + 1;
        end
    end

    always @(posedge clk_pix) begin
        if (!rst_n) begin
            edges    <= 0;
            rst_seen <= 1'b1;
        end else begin
            edges <= edges + 1;
        end
    end

    // sampled half a cycle after the dut updates
    always @(negedge clk_pix) begin
        int          n, rem, fr, x, y, b, tx;
        rgb_t        exp_rgb;
        logic [1:0]  exp_sync;
        logic [1:0]  act_sync;
        act_sync = {vga_hsync, vga_vsync};
        if (rst_seen && edges == 0) begin
            if (!rst_bad && (vga_rgb != '0 || act_sync != 2'b11)) begin
                rst_bad  = 1'b1;
                rst_rgb  = vga_rgb;
                rst_sync = act_sync;
            end
        end else if (edges == 1) begin
            if (rst_bad) begin
                $display("Fail reset expected rgb 000 sync 11, actual rgb %h sync %b",
                         rst_rgb, rst_sync);
                fails++;
            end else begin
                $display("ok   reset: idle outputs");
                passes++;
            end
        end
        if (edges >= 3 && !done) begin
            n   = edges - 3;              // two cycle port latency
            fr  = n / frame_cycles;
            rem = n % frame_cycles;
            x   = rem % int'(h_total);
            y   = rem / int'(h_total);
            if (n == 0) begin
                for (int i = 0; i < sf_layers; i++) begin
                    st[i] = sf_seed[i];
                    ph[i] = 0;
                end
            end
            exp_rgb = star_colour(x, y);
            b  = p * fields;
            tx = (td[b+1] == 16'd2) ? 0 : int'(td[b+3]);
            if (td[b] == 16'h00ff) begin
                if (!scan_on) done = 1'b1;
            end else if (fr == int'(td[b+2]) && x == tx && y == int'(td[b+4])) begin
                if (td[b+1] == 16'd2) begin
                    scan_on    = 1'b1;
                    scan_fr    = fr;
                    scan_y1    = y + int'(td[b+3]);
                    scan_bad   = 0;
                    scan_stars = 0;
                end else begin
                    if (td[b+1] == 16'd0) exp_rgb = rgb_t'(td[b+5][11:0]);
                    exp_sync = td[b+6][1:0];
                    if (vga_rgb != exp_rgb || act_sync != exp_sync) begin
                        $display("Fail %s f%0d (%0d,%0d) expected %h sync %b, actual %h sync %b",
                                 test_name(td[b]), fr, x, y, exp_rgb, exp_sync, vga_rgb, act_sync);
                        fails++;
                    end else begin
                        $display("ok   %s f%0d (%0d,%0d) rgb %h sync %b",
                                 test_name(td[b]), fr, x, y, vga_rgb, act_sync);
                        passes++;
                    end
                end
                p++;
            end
            if (scan_on) begin
                if (fr == scan_fr && y < scan_y1) begin
                    if (exp_rgb != '0) scan_stars++;
                    if (vga_rgb != exp_rgb) begin
                        if (scan_bad == 0) begin
                            scan_exp = exp_rgb;
                            scan_act = vga_rgb;
                        end
                        scan_bad++;
                    end
                end else begin
                    scan_on = 1'b0;
                    if (scan_bad != 0) begin
                        $display("Fail stars scan f%0d expected %h actual %h, %0d pixels off",
                                 scan_fr, scan_exp, scan_act, scan_bad);
                        fails++;
                    end else begin
                        $display("ok   stars scan f%0d, %0d star pixels", scan_fr, scan_stars);
                        passes++;
                    end
                end
            end
            // each layer restarts after a frame plus its drift
            for (int i = 0; i < sf_layers; i++) begin
                ph[i]++;
                if (ph[i] == frame_cycles + sf_inc[i]) begin
                    st[i] = sf_seed[i];
                    ph[i] = 0;
                end else begin
                    st[i] = lfsr_next(st[i]);
                end
            end
        end
    end

endmodule

//--- sim/space_f_tb.sv
//////////////////////////////////////////////////////////////////////
// space F testbench, clock, reset, dut and checker, run limit and
// the final verdict
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module space_f_tb
    import display_pkg::*;
    import sprite_pkg::*;
;

    localparam int reset_cycles = 16;
    localparam int frame_cycles = int'(h_total) * int'(v_total);

    logic clk_pix = 1'b0;
    logic rst_n   = 1'b0;   // held from time zero
    logic vga_hsync;
    logic vga_vsync;
    rgb_t vga_rgb;
    logic done;
    int   passes;
    int   fails;
    int   frames;
    int   cycles = 0;

    always #5 clk_pix = ~clk_pix;  // 100 MHz stand-in for the pixel clock

    initial begin
        repeat (reset_cycles) @(negedge clk_pix);
        rst_n = 1'b1;  // falling edge drive
    end

    space_f_top u_dut (
        .clk_pix,
        .rst_n,
        .vga_hsync,
        .vga_vsync,
        .vga_rgb
    );

    space_f_checker u_checker (
        .clk_pix,
        .rst_n,
        .vga_hsync,
        .vga_vsync,
        .vga_rgb,
        .done,
        .passes,
        .fails,
        .frames
    );

    // one frame of slack past the last probe
    always @(posedge clk_pix) begin
        cycles <= cycles + 1;
        if (done) begin
            $display("%0d passed, %0d failed, %0d assertion failures", passes, fails,
                     u_dut.u_props.errors);
            if (fails == 0 && u_dut.u_props.errors == 0) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
            $finish;
        end else if (cycles >= (frames + 1) * frame_cycles + reset_cycles) begin
            $display("timed out after %0d cycles with probes still pending", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

endmodule

//--- project.f
design/display_pkg.sv
design/sprite_pkg.sv
design/display_timings.sv
design/font_rom.sv
design/sprite.sv
design/starfield.sv
design/space_f_top.sv
sim/space_f_props.sv
sim/space_f_checker.sv
sim/space_f_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the space F testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f project.f --top-module space_f_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vspace_f_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench prints its verdict on a line of its own
if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
else
    exit 1
fi

//--- design/font_glyphs.mem
18
3C
66
66
7E
66
66
00
3C
66
C0
C0
C0
66
3C
00
FE
C0
C0
FC
C0
C0
FE
00
FE
C0
C0
FC
C0
C0
C0
00
7C
C6
C0
7C
06
C6
7C
00

//--- sim/space_f_testdata.mem
// name kind frame x y rgb sync, name 1 blank 2 sync 3 sprite 4 edge 5 stars, ff ends
// kind 0 exact rgb, 1 rgb from star model, 2 scan x lines from y with star model
01 0 0 280 000 000 3
02 0 0 28F 00A 000 3
02 0 0 290 00A 000 1
02 0 0 2EF 00A 000 1
02 0 0 2F0 00A 000 3
05 2 0 010 010 000 3
04 1 0 0C8 06F 000 3
03 0 0 0C0 070 FC0 3
03 1 0 1A0 070 000 3
03 0 0 19F 08F FC0 3
04 1 0 0BF 096 000 3
04 1 0 1C0 096 000 3
03 0 0 0FF 0C8 FC0 3
03 1 0 100 0C8 000 3
01 0 0 2BC 0C8 000 1
03 0 0 160 0DC FC0 3
03 1 0 180 0DC 000 3
03 0 0 0DF 14F FC0 3
03 1 0 0C0 16F 000 3
04 1 0 0C8 170 000 3
05 1 0 1F4 190 000 3
02 0 0 000 1E9 000 3
02 0 0 000 1EA 000 2
02 0 0 2BC 1EA 000 0
02 0 0 000 1EC 000 3
05 2 1 010 010 000 3
03 0 1 0C0 070 FC0 3
05 1 1 1F4 190 000 3
FF 0 0 000 000 000 0
